//--- csr_unit_top.f
+incdir+design
design/csr_pkg.sv
design/csr_stage.sv
design/csr_file.sv
design/csr_host_port.sv
design/csr_unit_top.sv
sim/csr_clock_gen.sv
sim/tb_csr_unit.sv

//--- design/csr_file.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_file (
    input  logic                   clk,
    input  csr_pkg::csr_addr_u     stage_raddr,
    input  logic [`CSR_ADDR_W-1:0] host_raddr,
    input  logic                   file_we,
    input  logic [`CSR_ADDR_W-1:0] file_waddr,
    input  logic [`CSR_XLEN-1:0]   file_wdata,
    output logic [`CSR_XLEN-1:0]   stage_rword,
    output logic [`CSR_XLEN-1:0]   host_rword,
    output logic [`CSR_XLEN-1:0]   mtvec_word
);

    // Words are kept in native order.
    logic [`CSR_XLEN-1:0] mem [0:`CSR_DEPTH-1];

    always_ff @(posedge clk) begin
        if (file_we) begin
            mem[file_waddr] <= file_wdata;
        end
    end

    assign stage_rword = mem[stage_raddr.flat];
    assign host_rword  = mem[host_raddr];
    assign mtvec_word  = mem[`CSR_MTVEC]; // Trap base is always visible.

    // Either the stage or the host drives the write address, never neither.
    a_waddr_known: assert property (
        @(posedge clk) file_we |-> !$isunknown(file_waddr)
    );

endmodule

//--- design/csr_host_port.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_host_port (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`CSR_ADDR_W-1:0] wb_adr,
    input  logic [`CSR_XLEN-1:0]   wb_dat_w,
    input  logic                   wb_req_we,
    input  logic [`CSR_ADDR_W-1:0] wb_req_addr,
    input  logic [`CSR_XLEN-1:0]   wb_req_data,
    input  logic [`CSR_XLEN-1:0]   host_rword,
    output logic [`CSR_XLEN-1:0]   wb_dat_r,
    output logic                   wb_ack,
    output logic [`CSR_ADDR_W-1:0] host_raddr,
    output logic                   file_we,
    output logic [`CSR_ADDR_W-1:0] file_waddr,
    output logic [`CSR_XLEN-1:0]   file_wdata
);

    logic acked;    // Set once the current strobe has been answered.
    logic host_go;

    // The pipeline cannot stall, so the host only gets a slot when no write-back is due.
    assign host_go = wb_cyc && wb_stb && !acked && !wb_req_we;

    assign host_raddr = wb_adr;

    // One write port, with the pipeline taking precedence.
    assign file_we    = wb_req_we || (host_go && wb_we);
    assign file_waddr = wb_req_we ? wb_req_addr : wb_adr;
    assign file_wdata = wb_req_we ? wb_req_data : wb_dat_w;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
            acked  <= 1'b0;
        end else begin
            wb_ack <= host_go;
            if (host_go) begin
                acked <= 1'b1;
            end else if (!wb_stb) begin
                acked <= 1'b0; // The master has ended the strobe.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (host_go && !wb_we) begin
            wb_dat_r <= host_rword;
        end
    end

    a_ack_requested: assert property (
        @(posedge clk) disable iff (rst)
        wb_ack |-> $past(wb_cyc && wb_stb)
    );

endmodule

//--- design/csr_params.svh
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// Data path width of the RV32 core.
`define CSR_XLEN 32

// CSR address space as defined by the privileged ISA.
`define CSR_ADDR_W 12
`define CSR_DEPTH 4096

// Fixed machine-mode registers used by the stage.
`define CSR_MTVEC 12'h305
`define CSR_MCAUSE 12'h342

// Environment call from M-mode.
`define CSR_ECALL_CAUSE 11

`endif

//--- design/csr_pkg.sv
`include "csr_params.svh"

package csr_pkg;

    // Command from decode.
    typedef enum logic [2:0] {
        CSR_X = 3'd0,   // No CSR access.
        CSR_W = 3'd1,
        CSR_S = 3'd2,
        CSR_C = 3'd3,
        CSR_E = 3'd4    // Environment call.
    } csr_cmd_e;

    // Address layout from the privileged spec.
    typedef struct packed {
        logic [1:0] access;   // 2'b11 marks the read-only space.
        logic [1:0] priv;
        logic [7:0] index;
    } csr_addr_fields_t;

    // The same address word seen as a storage index or as its fields.
    typedef union packed {
        logic [`CSR_ADDR_W-1:0] flat;
        csr_addr_fields_t       fields;
    } csr_addr_u;

endpackage

//--- design/csr_stage.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   branch_hazard,
    input  csr_pkg::csr_cmd_e      csr_cmd,
    input  logic [`CSR_XLEN-1:0]   op1_data,
    input  logic [`CSR_XLEN-1:0]   imm_i,
    input  logic [`CSR_XLEN-1:0]   stage_rword,
    input  logic [`CSR_XLEN-1:0]   mtvec_word,
    output csr_pkg::csr_addr_u     stage_raddr,
    output logic [`CSR_XLEN-1:0]   csr_rdata,
    output logic [`CSR_XLEN-1:0]   trap_vector,
    output logic                   wb_req_we,
    output logic [`CSR_ADDR_W-1:0] wb_req_addr,
    output logic [`CSR_XLEN-1:0]   wb_req_data
);
    import csr_pkg::*;

    csr_cmd_e             cmd;
    csr_cmd_e             save_cmd;
    csr_addr_u            save_addr;
    logic [`CSR_XLEN-1:0] save_op;
    logic                 read_only;
    logic                 bypass_hit;

    assign cmd = branch_hazard ? CSR_X : csr_cmd; // A hazard from write-back kills the access.

    // An ecall always targets mcause, everything else takes its address from the immediate.
    always_comb begin
        if (cmd == CSR_E) begin
            stage_raddr.flat = `CSR_MCAUSE;
        end else begin
            stage_raddr.flat = imm_i[`CSR_ADDR_W-1:0];
        end
    end

    // The previous command is still in flight when its address is read again.
    // Its result has not reached storage yet, so it is forwarded here.
    assign bypass_hit = wb_req_we && (wb_req_addr == stage_raddr.flat);

    always_ff @(posedge clk) begin
        if (rst) begin
            save_cmd <= CSR_X;
        end else begin
            save_cmd <= cmd;
        end
    end

    always_ff @(posedge clk) begin
        save_addr   <= stage_raddr;
        save_op     <= op1_data;
        csr_rdata   <= bypass_hit ? wb_req_data : stage_rword;
        trap_vector <= mtvec_word;
    end

    // Read-modify-write on the value that was returned to the pipeline.
    always_comb begin
        case (save_cmd)
            CSR_W:   wb_req_data = save_op;
            CSR_S:   wb_req_data = csr_rdata | save_op;
            CSR_C:   wb_req_data = csr_rdata & ~save_op;
            CSR_E:   wb_req_data = `CSR_ECALL_CAUSE;
            default: wb_req_data = csr_rdata;
        endcase
    end

    assign read_only   = (save_addr.fields.access == 2'b11);
    assign wb_req_we   = (save_cmd != CSR_X) && !read_only; // Writes to read-only CSRs are dropped.
    assign wb_req_addr = save_addr.flat;

    a_idle_after_rst: assert property (@(posedge clk) rst |=> !wb_req_we);

    // The host port forwards this request to storage without a second check.
    a_no_ro_commit: assert property (
        @(posedge clk) disable iff (rst)
        wb_req_we |-> (wb_req_addr[`CSR_ADDR_W-1 -: 2] != 2'b11)
    );

endmodule

//--- design/csr_unit_top.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_unit_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   branch_hazard,
    input  csr_pkg::csr_cmd_e      csr_cmd,
    input  logic [`CSR_XLEN-1:0]   op1_data,
    input  logic [`CSR_XLEN-1:0]   imm_i,
    output logic [`CSR_XLEN-1:0]   csr_rdata,
    output logic [`CSR_XLEN-1:0]   trap_vector,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`CSR_ADDR_W-1:0] wb_adr,
    input  logic [`CSR_XLEN-1:0]   wb_dat_w,
    output logic [`CSR_XLEN-1:0]   wb_dat_r,
    output logic                   wb_ack
);
    import csr_pkg::*;

    csr_addr_u              stage_raddr;
    logic [`CSR_XLEN-1:0]   stage_rword;
    logic [`CSR_XLEN-1:0]   mtvec_word;
    logic                   wb_req_we;
    logic [`CSR_ADDR_W-1:0] wb_req_addr;
    logic [`CSR_XLEN-1:0]   wb_req_data;
    logic [`CSR_ADDR_W-1:0] host_raddr;
    logic [`CSR_XLEN-1:0]   host_rword;
    logic                   file_we;
    logic [`CSR_ADDR_W-1:0] file_waddr;
    logic [`CSR_XLEN-1:0]   file_wdata;

    csr_stage u_stage (
        .clk(clk), .rst(rst), .branch_hazard(branch_hazard),
        .csr_cmd(csr_cmd), .op1_data(op1_data), .imm_i(imm_i),
        .stage_rword(stage_rword), .mtvec_word(mtvec_word),
        .stage_raddr(stage_raddr), .csr_rdata(csr_rdata), .trap_vector(trap_vector),
        .wb_req_we(wb_req_we), .wb_req_addr(wb_req_addr), .wb_req_data(wb_req_data)
    );

    csr_file u_file (
        .clk(clk), .stage_raddr(stage_raddr), .host_raddr(host_raddr),
        .file_we(file_we), .file_waddr(file_waddr), .file_wdata(file_wdata),
        .stage_rword(stage_rword), .host_rword(host_rword), .mtvec_word(mtvec_word)
    );

    csr_host_port u_host_port (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
        .wb_req_we(wb_req_we), .wb_req_addr(wb_req_addr), .wb_req_data(wb_req_data),
        .host_rword(host_rword), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .host_raddr(host_raddr),
        .file_we(file_we), .file_waddr(file_waddr), .file_wdata(file_wdata)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the CSR unit testbench with Verilator, run it and scan the log for the result.
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f csr_unit_top.f --top-module tb_csr_unit -o tb_csr_unit > sim.log 2>&1 \
    && ./obj_dir/tb_csr_unit >> sim.log 2>&1
cat sim.log
grep -q "^TEST OK$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- sim/csr_clock_gen.sv
`timescale 1ns/1ps

module csr_clock_gen (
    output logic clk,
    output logic rst
);

    // 40 ns period.
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0; // Released after two rising edges.
    end

endmodule

//--- sim/tb_csr_unit.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module tb_csr_unit;
    import csr_pkg::*;

    localparam int N_ADDRS      = 20;
    localparam int HOST_XFERS   = 80;  // Up to four cycles each with the strobe gap.
    localparam int PIPE_CYCLES  = 60;
    localparam int SCHED_CYCLES = 4 * HOST_XFERS + PIPE_CYCLES;
    localparam int CYCLE_LIMIT  = 4 * SCHED_CYCLES;

    logic                   clk;
    logic                   rst;
    logic                   branch_hazard;
    csr_cmd_e               csr_cmd;
    logic [`CSR_XLEN-1:0]   op1_data;
    logic [`CSR_XLEN-1:0]   imm_i;
    logic [`CSR_XLEN-1:0]   csr_rdata;
    logic [`CSR_XLEN-1:0]   trap_vector;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [`CSR_ADDR_W-1:0] wb_adr;
    logic [`CSR_XLEN-1:0]   wb_dat_w;
    logic [`CSR_XLEN-1:0]   wb_dat_r;
    logic                   wb_ack;

    logic [`CSR_XLEN-1:0]   ref_mem [0:`CSR_DEPTH-1]; // Expected CSR contents.
    logic [`CSR_ADDR_W-1:0] addrs [0:N_ADDRS-1];
    logic [`CSR_XLEN-1:0]   val;
    logic [`CSR_ADDR_W-1:0] a;
    integer                 seed;
    int                     cycles;
    string                  test_name;

    logic                   exp_valid;   // Launched together with the command.
    logic [`CSR_XLEN-1:0]   exp_rdata;
    logic                   chk_valid;   // Delayed like the registered read.
    logic [`CSR_XLEN-1:0]   chk_rdata;
    logic                   host_rd_chk;
    logic [`CSR_XLEN-1:0]   host_exp;
    logic                   pipe_busy;   // Pipeline write-backs still to come.

    csr_clock_gen u_clock_gen (.clk(clk), .rst(rst));

    csr_unit_top DUT (.*);

    // New CSR value after one command, with pipeline writes to the read-only space dropped.
    function automatic logic [`CSR_XLEN-1:0] csr_ref_rmw(input csr_cmd_e cmd,
            input logic [`CSR_XLEN-1:0] old, input logic [`CSR_XLEN-1:0] op,
            input logic [`CSR_ADDR_W-1:0] addr);
        if (cmd == CSR_X || addr[`CSR_ADDR_W-1 -: 2] == 2'b11) begin
            return old;
        end
        case (cmd)
            CSR_W:   return op;
            CSR_S:   return old | op;
            CSR_C:   return old & ~op;
            default: return `CSR_ECALL_CAUSE;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [`CSR_XLEN-1:0] expected,
            input logic [`CSR_XLEN-1:0] actual);
        $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        $display("TEST FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic pipe_cmd(input csr_cmd_e cmd, input logic [`CSR_ADDR_W-1:0] addr,
            input logic [`CSR_XLEN-1:0] op, input logic hazard);
        logic [`CSR_ADDR_W-1:0] eff;
        @(posedge clk);
        eff = (cmd == CSR_E) ? `CSR_MCAUSE : addr;
        csr_cmd       <= cmd;
        imm_i         <= {{20{addr[11]}}, addr}; // Sign-extended I-type immediate.
        op1_data      <= op;
        branch_hazard <= hazard;
        exp_valid     <= !hazard;
        exp_rdata     <= ref_mem[eff];
        if (!hazard) begin
            ref_mem[eff] = csr_ref_rmw(cmd, ref_mem[eff], op, eff);
        end
    endtask

    task automatic idle_cycle(input int n);
        repeat (n) begin
            @(posedge clk);
            csr_cmd       <= CSR_X;
            branch_hazard <= 1'b0;
            exp_valid     <= 1'b0;
        end
    endtask

    task automatic await_ack();
        do begin
            @(negedge clk);
        end while (!wb_ack);
    endtask

    // One Wishbone classic transfer; returns once the strobe is dropped.
    task automatic host_access(input logic we, input logic [`CSR_ADDR_W-1:0] addr,
            input logic [`CSR_XLEN-1:0] data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= addr;
        wb_dat_w <= data;
        host_exp    = ref_mem[addr];
        host_rd_chk = !we;
        await_ack();
        if (we) begin
            ref_mem[addr] = data;
        end
        @(posedge clk);
        host_rd_chk = 1'b0;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    always @(posedge clk) begin
        chk_valid <= exp_valid;
        chk_rdata <= exp_rdata;
    end

    always @(negedge clk) begin
        if (!rst && chk_valid) begin
            assert (csr_rdata === chk_rdata)
                else report_mismatch({test_name, " csr_rdata"}, chk_rdata, csr_rdata);
        end
        if (!rst && wb_ack) begin
            assert (!pipe_busy) else begin
                $display("The host was acknowledged while pipeline writes were still pending");
                $display("TEST FAILED");
                $fatal(1, "host port did not yield to the pipeline");
            end
            if (host_rd_chk) begin
                assert (wb_dat_r === host_exp)
                    else report_mismatch({test_name, " wb_dat_r"}, host_exp, wb_dat_r);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        seed          = 32'h65aab8a2;
        cycles        = 0;
        branch_hazard = 1'b0;
        csr_cmd       = CSR_X;
        op1_data      = '0;
        imm_i         = '0;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = '0;
        exp_valid     = 1'b0;
        exp_rdata     = '0;
        host_rd_chk   = 1'b0;
        host_exp      = '0;
        pipe_busy     = 1'b0;
        test_name     = "reset";
        wait (rst == 1'b0);

        test_name = "host_rw";
        for (int i = 0; i < N_ADDRS; i++) begin
            do begin
                val = $random(seed);
                a   = val[`CSR_ADDR_W-1:0];
            end while (a == `CSR_MTVEC || a == `CSR_MCAUSE);
            addrs[i] = a;
            host_access(1'b1, a, $random(seed));
        end
        host_access(1'b1, `CSR_MTVEC, 32'h8000_0100);
        host_access(1'b1, `CSR_MCAUSE, 32'h0000_0002);
        for (int i = 0; i < N_ADDRS; i++) begin
            host_access(1'b0, addrs[i], '0);
        end
        host_access(1'b0, `CSR_MTVEC, '0);
        host_access(1'b0, `CSR_MCAUSE, '0);
        @(negedge clk);
        assert (trap_vector === ref_mem[`CSR_MTVEC])
            else report_mismatch("host_rw trap_vector", ref_mem[`CSR_MTVEC], trap_vector);

        test_name = "pipe_rmw";
        for (int i = 0; i < N_ADDRS; i++) begin
            val = $random(seed);
            case (i % 3)
                0:       pipe_cmd(CSR_W, addrs[i], val, 1'b0);
                1:       pipe_cmd(CSR_S, addrs[i], val, 1'b0);
                default: pipe_cmd(CSR_C, addrs[i], val, 1'b0);
            endcase
        end
        idle_cycle(2);
        for (int i = 0; i < N_ADDRS; i++) begin
            host_access(1'b0, addrs[i], '0);
        end

        test_name = "bypass";
        host_access(1'b1, 12'h340, 32'h0f0f_0f0f);
        pipe_cmd(CSR_W, 12'h340, $random(seed), 1'b0);
        pipe_cmd(CSR_S, 12'h340, $random(seed), 1'b0);
        pipe_cmd(CSR_C, 12'h340, $random(seed), 1'b0);
        pipe_cmd(CSR_S, 12'h340, 32'h0000_00ff, 1'b0);
        idle_cycle(2);
        host_access(1'b0, 12'h340, '0);

        test_name = "ecall";
        pipe_cmd(CSR_E, 12'h000, '0, 1'b0);
        idle_cycle(2);
        host_access(1'b0, `CSR_MCAUSE, '0);

        test_name = "hazard";
        host_access(1'b1, `CSR_MCAUSE, 32'h0000_0007); // A squashed ecall must not restore 11.
        pipe_cmd(CSR_W, 12'h340, 32'hdead_beef, 1'b1);
        pipe_cmd(CSR_E, 12'h000, '0, 1'b1);
        idle_cycle(2);
        host_access(1'b0, 12'h340, '0);
        host_access(1'b0, `CSR_MCAUSE, '0);

        test_name = "read_only";
        host_access(1'b1, 12'hc00, 32'h1234_5678);
        pipe_cmd(CSR_W, 12'hc00, 32'hffff_0000, 1'b0);
        pipe_cmd(CSR_S, 12'hc00, 32'h0000_ffff, 1'b0);
        idle_cycle(2);
        host_access(1'b0, 12'hc00, '0);
        host_access(1'b1, 12'hc00, 32'hcafe_f00d);
        host_access(1'b0, 12'hc00, '0);

        test_name = "host_backpressure";
        host_access(1'b1, 12'h341, 32'h0000_0000);
        pipe_busy = 1'b1;
        fork
            begin
                for (int k = 0; k < 6; k++) begin
                    pipe_cmd(CSR_W, 12'h341, $random(seed), 1'b0);
                end
                idle_cycle(3); // The last write-back commits one edge before this returns.
                pipe_busy = 1'b0;
            end
            begin
                @(posedge clk);
                host_access(1'b1, 12'h343, 32'h5a5a_a5a5);
            end
        join
        host_access(1'b0, 12'h341, '0);
        host_access(1'b0, 12'h343, '0);

        idle_cycle(2);
        $display("TEST OK");
        $finish;
    end

endmodule
